//--- Makefile
VERILATOR ?= verilator
TOP       ?= stackBank_tb
FILELIST  ?= stackBank.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation finished: PASS" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- stackBank.f
stackCfgPkg.sv
stackOpsPkg.sv
stackCommandRouter.sv
superStack.sv
stackResultCollector.sv
stackBank.sv
stackBank_props.sv
stackBank_tb.sv

//--- stackBank.sv
// Top level of the multi-context stack bank that ties the command router, one stack per context and the result collector together
`timescale 1ns/1ps

module stackBank (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmdValid,
  input  stackCfgPkg::ctx_t         cmdCtx,
  input  stackOpsPkg::stackOp_t     cmdOp,
  input  stackCfgPkg::frame_t       cmdData,
  input  stackCfgPkg::stackIndex_t  cmdOffset,
  input  stackCfgPkg::stackIndex_t  cmdLimit,
  input  stackCfgPkg::stackIndex_t  cmdNewIndex,
  output logic                      resultValid,
  output stackCfgPkg::ctx_t         resultCtx,
  output stackCfgPkg::frame_t       resultTop,
  output stackCfgPkg::frame_t       resultNext,
  output stackCfgPkg::frame_t       resultThird,
  output stackCfgPkg::stackIndex_t  resultIndex,
  output stackOpsPkg::stackStatus_t resultStatus
);
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  stackOp_t     stackOp    [numContexts];
  frame_t       topFrame   [numContexts];
  frame_t       nextFrame  [numContexts];
  frame_t       thirdFrame [numContexts];
  stackIndex_t  index      [numContexts];
  stackStatus_t status     [numContexts];

  // Shared operand buses from the router
  frame_t       opData;
  stackIndex_t  opOffset;
  stackIndex_t  opLimit;
  stackIndex_t  opNewIndex;

  logic         tagValid;
  ctx_t         tagCtx;
  logic         tagBadCtx;

  stackCommandRouter router (
    .clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdCtx(cmdCtx), .cmdOp(cmdOp),
    .cmdData(cmdData), .cmdOffset(cmdOffset), .cmdLimit(cmdLimit),
    .cmdNewIndex(cmdNewIndex), .stackOp(stackOp), .opData(opData), .opOffset(opOffset),
    .opLimit(opLimit), .opNewIndex(opNewIndex), .tagValid(tagValid), .tagCtx(tagCtx),
    .tagBadCtx(tagBadCtx)
  );

  for (genvar g = 0; g < numContexts; g++) begin : genStack
    superStack stack (
      .clk(clk), .reset(reset), .op(stackOp[g]), .data(opData), .offset(opOffset),
      .underflowLimit(opLimit), .newIndex(opNewIndex), .topFrame(topFrame[g]),
      .nextFrame(nextFrame[g]), .thirdFrame(thirdFrame[g]), .index(index[g]),
      .status(status[g])
    );
  end

  stackResultCollector collector (
    .clk(clk), .reset(reset), .tagValid(tagValid), .tagCtx(tagCtx), .tagBadCtx(tagBadCtx),
    .topFrame(topFrame), .nextFrame(nextFrame), .thirdFrame(thirdFrame), .index(index),
    .status(status), .resultValid(resultValid), .resultCtx(resultCtx),
    .resultTop(resultTop), .resultNext(resultNext), .resultThird(resultThird),
    .resultIndex(resultIndex), .resultStatus(resultStatus)
  );

endmodule

//--- stackBank_props.sv
// Concurrent checks on the bank result pulse, reset state and context tag, bound into the top level
`timescale 1ns/1ps

module stackBankProps (
  input logic                      clk,
  input logic                      reset,
  input logic                      tagValid,
  input logic                      resultValid,
  input stackCfgPkg::ctx_t         resultCtx,
  input stackCfgPkg::stackIndex_t  resultIndex,
  input stackOpsPkg::stackStatus_t resultStatus
);
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  // Router tag, collector delay, then the result register
  pulseFollowsTag: assert property (@(posedge clk) disable iff (reset)
    resultValid == $past(tagValid, 2))
    else $error("resultValid is not two cycles behind tagValid");

  // No pulse during reset or right after it
  quietAfterReset: assert property (@(posedge clk)
    ($past(reset) || $past(reset, 2)) |-> (!resultValid && resultStatus == stEmpty))
    else $error("Result is not in its reset state");

  badCtxOnlyOutside: assert property (@(posedge clk) disable iff (reset)
    (resultValid && resultStatus == stBadContext) |-> int'(resultCtx) >= numContexts)
    else $error("stBadContext reported for a context inside the bank");

  outsideIsBadCtx: assert property (@(posedge clk) disable iff (reset)
    (resultValid && int'(resultCtx) >= numContexts) |-> resultStatus == stBadContext)
    else $error("Context outside the bank without stBadContext");

  indexInRange: assert property (@(posedge clk) disable iff (reset)
    resultValid |-> resultIndex <= stackIndex_t'(stackCapacity))
    else $error("resultIndex above the stack capacity");

endmodule

bind stackBank stackBankProps bankProps (
  .clk(clk), .reset(reset), .tagValid(tagValid), .resultValid(resultValid),
  .resultCtx(resultCtx), .resultIndex(resultIndex), .resultStatus(resultStatus)
);

//--- stackBank_stim.txt
# ctx op data offset limit newIndex | expected top next third index status
# all fields hex, op and status use the stackOpsPkg encodings
0 0 00 00 00 00  00 00 00 00 1
1 0 00 00 00 00  00 00 00 00 1
2 0 00 00 00 00  00 00 00 00 1
1 1 01 00 00 00  01 00 00 01 0
1 1 02 00 00 00  02 01 00 02 0
1 1 03 00 00 00  03 02 01 03 0
1 1 04 00 00 00  04 03 02 04 0
1 1 05 00 00 00  05 04 03 05 0
1 1 06 00 00 00  06 05 04 06 0
1 1 07 00 00 00  07 06 05 07 0
1 1 08 00 00 00  08 07 06 08 0
1 1 09 00 00 00  09 08 07 09 0
1 1 0a 00 00 00  0a 09 08 0a 0
1 1 0b 00 00 00  0b 0a 09 0b 0
1 1 0c 00 00 00  0c 0b 0a 0c 0
1 1 0d 00 00 00  0d 0c 0b 0d 0
1 1 0e 00 00 00  0e 0d 0c 0e 0
1 1 0f 00 00 00  0f 0e 0d 0f 0
1 1 10 00 00 00  10 0f 0e 10 2
1 1 11 00 00 00  10 0f 0e 10 4
1 2 02 00 00 00  0d 0c 0b 0d 0
1 2 03 00 0a 00  0d 0c 0b 0d 3
1 3 55 00 0d 00  0d 0c 0b 0d 3
1 3 55 00 00 00  55 0c 0b 0d 0
1 2 00 00 0c 00  0c 0b 0a 0c 1
0 1 21 00 00 00  21 00 00 01 0
0 1 22 00 00 00  22 21 00 02 0
0 1 23 00 00 00  23 22 21 03 0
0 4 00 00 00 05  23 22 21 03 5
0 4 00 00 00 01  23 22 21 01 0
0 0 00 00 00 00  21 00 00 01 0
0 5 44 00 00 00  44 00 00 01 0
0 1 45 00 00 00  45 44 00 02 0
0 1 46 00 00 00  46 45 44 03 0
0 6 00 00 00 00  44 45 44 03 0
0 0 00 00 00 00  46 45 44 03 0
0 7 55 01 00 00  46 45 44 03 0
0 0 00 00 00 00  46 55 44 03 0
0 7 66 02 00 00  66 55 44 03 0
0 6 00 03 00 00  66 55 44 03 6
2 1 a1 00 00 00  a1 00 00 01 0
0 0 00 00 00 00  66 55 44 03 0
3 1 ee 00 00 00  00 00 00 00 7
2 1 a2 00 00 00  a2 a1 00 02 0
0 2 01 00 00 00  44 00 00 01 0
2 2 00 00 01 00  a1 00 00 01 1
1 0 00 00 00 00  0c 0b 0a 0c 0
3 0 00 00 00 00  00 00 00 00 7

//--- stackBank_tb.sv
// Stack bank testbench run from the Makefile that replays the stim file and checks each result
`timescale 1ns/1ps

module stackBank_tb;
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  localparam int    clkPeriod     = 8;  // ns
  localparam int    resetCycles   = 8;
  localparam int    rngSeed       = 32'h84de;
  localparam string stimFile      = "stackBank_stim.txt";
  localparam int    cyclesPerLine = 20;  // Watchdog margin per command
  localparam int    groupSize     = 4;   // Commands sent back to back

  typedef struct packed {
    ctx_t        ctx;
    stackOp_t    op;
    frame_t      data;
    stackIndex_t offset;
    stackIndex_t limit;
    stackIndex_t newIndex;
  } command_t;

  typedef struct packed {
    ctx_t         ctx;
    frame_t       top;
    frame_t       next;
    frame_t       third;
    stackIndex_t  index;
    stackStatus_t status;
  } expected_t;

  logic         clk = 1'b0;
  logic         reset;
  logic         cmdValid;
  ctx_t         cmdCtx;
  stackOp_t     cmdOp;
  frame_t       cmdData;
  stackIndex_t  cmdOffset;
  stackIndex_t  cmdLimit;
  stackIndex_t  cmdNewIndex;
  logic         resultValid;
  ctx_t         resultCtx;
  frame_t       resultTop;
  frame_t       resultNext;
  frame_t       resultThird;
  stackIndex_t  resultIndex;
  stackStatus_t resultStatus;

  command_t  cmdQ [$];
  expected_t expQ [$];  // One entry per result still to come
  int        numLines   = 0;
  int        numChecked = 0;
  bit        stimLoaded = 1'b0;

  stackBank dut_i (
    .clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdCtx(cmdCtx), .cmdOp(cmdOp),
    .cmdData(cmdData), .cmdOffset(cmdOffset), .cmdLimit(cmdLimit),
    .cmdNewIndex(cmdNewIndex), .resultValid(resultValid), .resultCtx(resultCtx),
    .resultTop(resultTop), .resultNext(resultNext), .resultThird(resultThird),
    .resultIndex(resultIndex), .resultStatus(resultStatus)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic compareFrame(input string what, input frame_t got, input frame_t want);
    if (got !== want)
      failRun($sformatf("** Error at %0t ns: %s is %02h, expected %02h", $time, what, got, want));
  endtask

  task automatic compareIndex(input string what, input stackIndex_t got, input stackIndex_t want);
    if (got !== want)
      failRun($sformatf("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want));
  endtask

  task automatic compareStatus(input string what, input stackStatus_t got,
                               input stackStatus_t want);
    if (got !== want)
      failRun($sformatf("** Error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                        want.name()));
  endtask

  // Each line gives one command and the result it must produce
  task automatic loadStim();
    int        fd;
    int        fields;
    int        f [11];
    string     line;
    command_t  cmd;
    expected_t want;
    fd = $fopen(stimFile, "r");
    if (fd == 0)
      failRun({"Cannot open the stim file ", stimFile});
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#")
        continue;  // Blank line or column legend
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                       f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
      if (fields != 11)
        failRun({"A stim line has missing fields: ", line});
      cmd.ctx       = ctx_t'(f[0]);
      cmd.op        = stackOp_t'(f[1]);
      cmd.data      = frame_t'(f[2]);
      cmd.offset    = stackIndex_t'(f[3]);
      cmd.limit     = stackIndex_t'(f[4]);
      cmd.newIndex  = stackIndex_t'(f[5]);
      want.ctx      = ctx_t'(f[0]);  // Result carries the command's context
      want.top      = frame_t'(f[6]);
      want.next     = frame_t'(f[7]);
      want.third    = frame_t'(f[8]);
      want.index    = stackIndex_t'(f[9]);
      want.status   = stackStatus_t'(f[10]);
      cmdQ.push_back(cmd);
      expQ.push_back(want);
    end
    $fclose(fd);
    numLines = cmdQ.size();
    if (numLines == 0)
      failRun("The stim file holds no commands");
  endtask

  task automatic checkResult();
    expected_t want;
    string     tag;
    if (expQ.size() == 0)
      failRun("A result came out of the bank with no expected line left");
    want = expQ.pop_front();
    tag  = $sformatf("result %0d", numChecked + 1);
    if (resultCtx !== want.ctx)
      failRun($sformatf("Result %0d came back for context %0d instead of context %0d",
                        numChecked + 1, resultCtx, want.ctx));
    compareFrame({tag, " top frame"}, resultTop, want.top);
    compareFrame({tag, " next frame"}, resultNext, want.next);
    compareFrame({tag, " third frame"}, resultThird, want.third);
    compareIndex({tag, " index"}, resultIndex, want.index);
    compareStatus({tag, " status"}, resultStatus, want.status);
    numChecked++;
  endtask

  task automatic driveCommand(input command_t cmd);
    cmdValid    = 1'b1;
    cmdCtx      = cmd.ctx;
    cmdOp       = cmd.op;
    cmdData     = cmd.data;
    cmdOffset   = cmd.offset;
    cmdLimit    = cmd.limit;
    cmdNewIndex = cmd.newIndex;
    @(posedge clk);
    #1;
  endtask

  task automatic driveIdle();
    cmdValid = 1'b0;
    @(posedge clk);
    #1;
  endtask

  // Outputs change on the rising edge so results are sampled mid-cycle
  always @(negedge clk) begin
    if (reset === 1'b0 && resultValid === 1'b1)
      checkResult();
  end

  initial begin
    int idle;
    void'($urandom(rngSeed));
    reset       = 1'b1;
    cmdValid    = 1'b0;
    cmdCtx      = '0;
    cmdOp       = opNone;
    cmdData     = '0;
    cmdOffset   = '0;
    cmdLimit    = '0;
    cmdNewIndex = '0;
    loadStim();
    stimLoaded = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    foreach (cmdQ[i]) begin
      driveCommand(cmdQ[i]);
      if ((i + 1) % groupSize == 0) begin
        idle = $urandom % 4;  // Gap between groups
        repeat (idle) driveIdle();
      end
    end
    driveIdle();
    wait (numChecked == numLines);
    repeat (4) @(posedge clk);  // Room for a stray extra pulse
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    longint limitCycles;
    wait (stimLoaded);
    limitCycles = longint'(numLines) * cyclesPerLine + resetCycles;
    #(limitCycles * clkPeriod);
    failRun($sformatf("Timeout: only %0d of %0d results arrived within %0d cycles",
                      numChecked, numLines, limitCycles));
  end

endmodule

//--- stackCfgPkg.sv
// Stack bank geometry and payload types shared by the router, the stacks and the collector
package stackCfgPkg;

  // Frame payload
  localparam int frameWidth = 8;

  // Frame memory addressing
  localparam int addrBits = 4;
  localparam int stackCapacity = 1 << addrBits;  // Frames per stack

  // One bit wider than the address so an index can sit at full capacity
  localparam int indexWidth = addrBits + 1;

  // Contexts served by the bank
  localparam int numContexts = 3;
  localparam int ctxWidth = 2;

  // One stack frame
  typedef logic [frameWidth-1:0] frame_t;

  // Index, offset, underflow limit and new index all share this width
  typedef logic [indexWidth-1:0] stackIndex_t;

  // Context number carried with each command and result
  typedef logic [ctxWidth-1:0] ctx_t;

endpackage

//--- stackCommandRouter.sv
// Registers each incoming command and steers its operation to the addressed context stack
`timescale 1ns/1ps

module stackCommandRouter (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmdValid,
  input  stackCfgPkg::ctx_t         cmdCtx,
  input  stackOpsPkg::stackOp_t     cmdOp,
  input  stackCfgPkg::frame_t       cmdData,
  input  stackCfgPkg::stackIndex_t  cmdOffset,
  input  stackCfgPkg::stackIndex_t  cmdLimit,
  input  stackCfgPkg::stackIndex_t  cmdNewIndex,
  output stackOpsPkg::stackOp_t     stackOp [stackCfgPkg::numContexts],
  output stackCfgPkg::frame_t       opData,
  output stackCfgPkg::stackIndex_t  opOffset,
  output stackCfgPkg::stackIndex_t  opLimit,
  output stackCfgPkg::stackIndex_t  opNewIndex,
  output logic                      tagValid,
  output stackCfgPkg::ctx_t         tagCtx,
  output logic                      tagBadCtx
);
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  logic                   ctxInRange;
  logic [numContexts-1:0] ctxSelect;  // One-hot target stack

  assign ctxInRange = int'(cmdCtx) < numContexts;

  // Decode the context, nothing selected for an idle cycle or a bad context
  always_comb begin
    for (int i = 0; i < numContexts; i++) begin
      ctxSelect[i] = cmdValid && ctxInRange && (cmdCtx == ctx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < numContexts; i++) begin
        stackOp[i] <= opNone;
      end
      tagValid  <= 1'b0;
      tagBadCtx <= 1'b0;
    end else begin
      for (int i = 0; i < numContexts; i++) begin
        stackOp[i] <= ctxSelect[i] ? cmdOp : opNone;  // Others just refresh
      end
      tagValid  <= cmdValid;
      tagBadCtx <= cmdValid && !ctxInRange;
    end
  end

  // Shared operand buses, held between commands
  always_ff @(posedge clk) begin
    if (cmdValid) begin
      opData     <= cmdData;
      opOffset   <= cmdOffset;
      opLimit    <= cmdLimit;
      opNewIndex <= cmdNewIndex;
      tagCtx     <= cmdCtx;
    end
  end

endmodule

//--- stackOpsPkg.sv
// Stack operation and status encodings used on the command path and in every result
package stackOpsPkg;

  // Operation applied to one stack in one cycle
  typedef enum logic [2:0] {
    opNone           = 3'd0,  // Refresh outputs only
    opPush           = 3'd1,
    opPop            = 3'd2,  // Removes data plus one frames
    opReplace        = 3'd3,  // Overwrite top of stack
    opIndexReset     = 3'd4,
    opIndexResetPush = 3'd5,
    opGet            = 3'd6,  // Read at offset
    opSet            = 3'd7   // Write at offset
  } stackOp_t;

  // Status reported with the top frames
  typedef enum logic [2:0] {
    stNone       = 3'd0,
    stEmpty      = 3'd1,  // Index sits on the underflow limit
    stFull       = 3'd2,
    stUnderflow  = 3'd3,
    stOverflow   = 3'd4,
    stBadIndex   = 3'd5,  // New index above current index
    stBadOffset  = 3'd6,
    stBadContext = 3'd7   // Set by the collector only
  } stackStatus_t;

endpackage

//--- stackResultCollector.sv
// Lines the command tag up with the stack update and registers the addressed stack's outputs as the bank result
`timescale 1ns/1ps

module stackResultCollector (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      tagValid,
  input  stackCfgPkg::ctx_t         tagCtx,
  input  logic                      tagBadCtx,
  input  stackCfgPkg::frame_t       topFrame   [stackCfgPkg::numContexts],
  input  stackCfgPkg::frame_t       nextFrame  [stackCfgPkg::numContexts],
  input  stackCfgPkg::frame_t       thirdFrame [stackCfgPkg::numContexts],
  input  stackCfgPkg::stackIndex_t  index      [stackCfgPkg::numContexts],
  input  stackOpsPkg::stackStatus_t status     [stackCfgPkg::numContexts],
  output logic                      resultValid,
  output stackCfgPkg::ctx_t         resultCtx,
  output stackCfgPkg::frame_t       resultTop,
  output stackCfgPkg::frame_t       resultNext,
  output stackCfgPkg::frame_t       resultThird,
  output stackCfgPkg::stackIndex_t  resultIndex,
  output stackOpsPkg::stackStatus_t resultStatus
);
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  logic dlyValid;   // Tag during the stack update cycle
  logic dlyBadCtx;
  ctx_t dlyCtx;

  always_ff @(posedge clk) begin
    if (reset) begin
      dlyValid  <= 1'b0;
      dlyBadCtx <= 1'b0;
    end else begin
      dlyValid  <= tagValid;
      dlyBadCtx <= tagBadCtx;
    end
  end

  always_ff @(posedge clk) begin
    dlyCtx <= tagCtx;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resultValid  <= 1'b0;
      resultStatus <= stEmpty;
    end else begin
      resultValid <= dlyValid;  // Single cycle pulse per command
      if (dlyValid)
        resultStatus <= dlyBadCtx ? stBadContext : status[dlyCtx];
    end
  end

  // Payload, zeroed for a context outside the bank
  always_ff @(posedge clk) begin
    if (dlyValid) begin
      resultCtx   <= dlyCtx;
      resultTop   <= dlyBadCtx ? '0 : topFrame[dlyCtx];
      resultNext  <= dlyBadCtx ? '0 : nextFrame[dlyCtx];
      resultThird <= dlyBadCtx ? '0 : thirdFrame[dlyCtx];
      resultIndex <= dlyBadCtx ? '0 : index[dlyCtx];
    end
  end

endmodule

//--- superStack.sv
// One context's hardware stack with frame memory, index and underflow checks and a registered view of its top three frames
`timescale 1ns/1ps

module superStack (
  input  logic                      clk,
  input  logic                      reset,
  input  stackOpsPkg::stackOp_t     op,
  input  stackCfgPkg::frame_t       data,
  input  stackCfgPkg::stackIndex_t  offset,
  input  stackCfgPkg::stackIndex_t  underflowLimit,
  input  stackCfgPkg::stackIndex_t  newIndex,
  output stackCfgPkg::frame_t       topFrame,
  output stackCfgPkg::frame_t       nextFrame,
  output stackCfgPkg::frame_t       thirdFrame,
  output stackCfgPkg::stackIndex_t  index,
  output stackOpsPkg::stackStatus_t status
);
  import stackCfgPkg::*;
  import stackOpsPkg::*;

  frame_t mem [stackCapacity];

  logic                wrEn;
  logic [addrBits-1:0] wrAddr;
  stackIndex_t         topPos;      // Position of the current top frame
  stackIndex_t         nextIndex;
  stackStatus_t        nextStatus;
  logic                refresh;     // Reload the three top frames
  logic                getHit;      // Get result goes to topFrame
  logic [frameWidth:0] popFloor;    // Wide enough for data plus limit
  frame_t              peekTop;
  frame_t              peekNext;
  frame_t              peekThird;

  assign topPos   = index - 1'b1;
  assign popFloor = data + underflowLimit;

  // Status seen from the underflow limit of the current command
  function automatic stackStatus_t statusOf(input stackIndex_t idx);
    if (idx == stackIndex_t'(stackCapacity))
      return stFull;
    else if (idx == underflowLimit)
      return stEmpty;
    else if (idx < underflowLimit)
      return stUnderflow;
    else
      return stNone;
  endfunction

  // Frame at depth below the new index, with this cycle's write forwarded
  function automatic frame_t peekFrame(input stackIndex_t depth);
    stackIndex_t pos;
    pos = nextIndex - depth;
    if (nextIndex < depth)
      return '0;  // Below the bottom
    if (wrEn && pos[addrBits-1:0] == wrAddr)
      return data;
    return mem[pos[addrBits-1:0]];
  endfunction

  always_comb begin
    wrEn       = 1'b0;
    wrAddr     = index[addrBits-1:0];
    nextIndex  = index;
    nextStatus = status;
    refresh    = 1'b0;
    getHit     = 1'b0;

    case (op)
      opNone: refresh = 1'b1;

      opPush: begin
        if (index == stackIndex_t'(stackCapacity)) begin
          nextStatus = stOverflow;
        end else begin
          wrEn      = 1'b1;
          nextIndex = index + 1'b1;
          refresh   = 1'b1;
        end
      end

      opPop: begin
        // Pop needs index - data above the limit
        if ({{(frameWidth + 1 - indexWidth){1'b0}}, index} <= popFloor) begin
          nextStatus = stUnderflow;
        end else begin
          nextIndex = index - stackIndex_t'(data) - 1'b1;
          refresh   = 1'b1;
        end
      end

      opReplace: begin
        if (index <= underflowLimit) begin
          nextStatus = stUnderflow;
        end else begin
          wrEn    = 1'b1;
          wrAddr  = topPos[addrBits-1:0];
          refresh = 1'b1;
        end
      end

      opIndexReset: begin
        if (newIndex > index) begin
          nextStatus = stBadIndex;
        end else begin
          nextIndex  = newIndex;
          nextStatus = statusOf(newIndex);  // Frames stay as they were
        end
      end

      opIndexResetPush: begin
        if (newIndex > index) begin
          nextStatus = stBadIndex;
        end else if (newIndex == stackIndex_t'(stackCapacity)) begin
          nextStatus = stOverflow;
        end else begin
          wrEn      = 1'b1;
          wrAddr    = newIndex[addrBits-1:0];
          nextIndex = newIndex + 1'b1;
          refresh   = 1'b1;
        end
      end

      opGet: begin
        if (offset >= index) begin
          nextStatus = stBadOffset;
        end else begin
          getHit     = 1'b1;
          nextStatus = stNone;
        end
      end

      opSet: begin
        if (offset >= index) begin
          nextStatus = stBadOffset;
        end else begin
          wrEn   = 1'b1;
          wrAddr = offset[addrBits-1:0];
          if (offset < topPos)
            nextStatus = stNone;
          else
            refresh = 1'b1;  // Top of stack changed
        end
      end

      default: nextStatus = status;
    endcase

    if (refresh)
      nextStatus = statusOf(nextIndex);
  end

  always_comb begin
    peekTop   = peekFrame(stackIndex_t'(1));
    peekNext  = peekFrame(stackIndex_t'(2));
    peekThird = peekFrame(stackIndex_t'(3));
  end

  always_ff @(posedge clk) begin
    if (wrEn)
      mem[wrAddr] <= data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      index  <= '0;
      status <= stEmpty;
    end else begin
      index  <= nextIndex;
      status <= nextStatus;
    end
  end

  // Frame view, an idle stack reloads it every cycle
  always_ff @(posedge clk) begin
    if (refresh) begin
      topFrame   <= peekTop;
      nextFrame  <= peekNext;
      thirdFrame <= peekThird;
    end else if (getHit) begin
      topFrame <= mem[offset[addrBits-1:0]];
    end
  end

endmodule
